//--- source/mips_dbg_pkg.sv
package mips_dbg_pkg;

   //////////////////////////////////////////////////
   // Basic widths
   //////////////////////////////////////////////////

   // One machine word, also the MISO width
   typedef logic [31:0] word_t;

   // Host argument word carried on MOSI
   localparam int DBG_ARG_W = 25;

   // Widest word address a memory write can carry
   localparam int MEM_AW_MAX = 16;

   //////////////////////////////////////////////////
   // Host debug port
   //////////////////////////////////////////////////

   // Chip-select codes driven by the host
   typedef enum logic [3:0] {
      CS_IDLE     = 4'd0,
      CS_LOAD_LO  = 4'd1,   // stage low half
      CS_LOAD_HI  = 4'd2,   // high half plus address, then write
      CS_READ_REG = 4'd3,
      CS_READ_PC  = 4'd4,
      CS_READ_MEM = 4'd5
   } dbg_cs_e;

   // Synchronized host events, 32 bits
   typedef struct packed {
      logic                 sclk_rise;
      logic                 step_rise;
      logic                 cont_rise;
      dbg_cs_e              cs;
      logic [DBG_ARG_W-1:0] arg;
   } dbg_evt_t;

   // Memory write request, address zero-extended to MEM_AW_MAX
   typedef struct packed {
      logic                  en;
      logic [MEM_AW_MAX-1:0] addr;
      word_t                 data;
   } mem_wr_t;

   typedef mem_wr_t imem_wr_t;
   typedef mem_wr_t dmem_wr_t;

   // Readback selection from control to core
   typedef struct packed {
      logic [4:0] reg_idx;
      logic [7:0] mem_addr;
   } peek_t;

   // Core state seen by the debug port
   typedef struct packed {
      word_t pc;
      word_t reg_val;
      word_t mem_val;
   } core_view_t;

   //////////////////////////////////////////////////
   // MIPS encodings
   //////////////////////////////////////////////////

   localparam logic [5:0] OP_RTYPE = 6'h00;
   localparam logic [5:0] OP_ADDI  = 6'h08;
   localparam logic [5:0] OP_LW    = 6'h23;
   localparam logic [5:0] OP_SW    = 6'h2b;
   localparam logic [5:0] OP_BEQ   = 6'h04;
   localparam logic [5:0] OP_HALT  = 6'h3f;

   localparam logic [5:0] FN_ADD = 6'h20;
   localparam logic [5:0] FN_SUB = 6'h22;
   localparam logic [5:0] FN_AND = 6'h24;
   localparam logic [5:0] FN_OR  = 6'h25;
   localparam logic [5:0] FN_SLT = 6'h2a;

endpackage

//--- source/dbg_host_sync.sv
`timescale 1ns/1ps

module dbg_host_sync import mips_dbg_pkg::*; #(
   parameter int SYNC_STAGES = 2
) (
   input  logic                 clk50,
   input  logic                 rst_n,
   input  logic                 sclk,
   input  logic                 step,
   input  logic                 cont,
   input  logic [3:0]           cs,
   input  logic [DBG_ARG_W-1:0] mosi,
   output dbg_evt_t             evt
);

   // All host pins travel as one bundle
   localparam int PIN_W = 3 + 4 + DBG_ARG_W;

   logic [PIN_W-1:0]                    pins;
   logic [SYNC_STAGES-1:0][PIN_W-1:0]   chain;
   logic [PIN_W-1:0]                    pins_s;
   logic [2:0]                          lvl_prev;

   assign pins = {sclk, step, cont, cs, mosi};

   //////////////////////////////////////////////////
   // Synchronizer chain
   //////////////////////////////////////////////////

   always_ff @(posedge clk50) begin
      if (!rst_n) begin
         chain <= '0;
      end else begin
         chain[0] <= pins;
         for (int i = 1; i < SYNC_STAGES; i++) begin
            chain[i] <= chain[i-1];
         end
      end
   end

   // Last stage is safe to use
   assign pins_s = chain[SYNC_STAGES-1];

   //////////////////////////////////////////////////
   // Edge detect and event register
   //////////////////////////////////////////////////

   always_ff @(posedge clk50) begin
      if (!rst_n) begin
         lvl_prev <= '0;
         evt      <= '0;
      end else begin
         // Old level of sclk, step, cont
         lvl_prev      <= pins_s[PIN_W-1 -: 3];
         // One-cycle pulse per rising edge
         evt.sclk_rise <= pins_s[PIN_W-1] & ~lvl_prev[2];
         evt.step_rise <= pins_s[PIN_W-2] & ~lvl_prev[1];
         evt.cont_rise <= pins_s[PIN_W-3] & ~lvl_prev[0];
         // cs and arg line up with the pulses
         evt.cs        <= dbg_cs_e'(pins_s[DBG_ARG_W +: 4]);
         evt.arg       <= pins_s[DBG_ARG_W-1:0];
      end
   end

endmodule

//--- source/dbg_ctrl.sv
`timescale 1ns/1ps

module dbg_ctrl import mips_dbg_pkg::*; #(
   parameter int IMEM_AW = 8
) (
   input  logic       clk50,
   input  logic       rst_n,
   input  dbg_evt_t   evt,
   input  logic       is_halt,
   input  core_view_t view,
   output logic       run_en,
   output imem_wr_t   imem_wr,
   output peek_t      peek,
   output word_t      miso
);

   typedef enum logic [1:0] {
      ST_HALTED = 2'd0,
      ST_RUN    = 2'd1,
      ST_STEP   = 2'd2
   } run_state_e;

   run_state_e  state;
   logic [15:0] lo_half;
   logic        halted;
   logic        cmd;

   assign halted = (state == ST_HALTED);
   // A command acts on the sclk edge only
   assign cmd    = evt.sclk_rise;

   //////////////////////////////////////////////////
   // Run control
   //////////////////////////////////////////////////

   always_ff @(posedge clk50) begin
      if (!rst_n) begin
         state <= ST_HALTED;
      end else begin
         case (state)
            ST_HALTED: begin
               if (evt.cont_rise) begin
                  state <= ST_RUN;
               end else if (evt.step_rise) begin
                  state <= ST_STEP;
               end
            end
            // Stay until the halt opcode shows up
            ST_RUN:  if (is_halt) state <= ST_HALTED;
            // Single enabled cycle
            ST_STEP: state <= ST_HALTED;
            default: state <= ST_HALTED;
         endcase
      end
   end

   assign run_en = (state == ST_RUN) || (state == ST_STEP);

   //////////////////////////////////////////////////
   // Program load and peek selection
   //////////////////////////////////////////////////

   always_ff @(posedge clk50) begin
      if (!rst_n) begin
         lo_half <= '0;
         peek    <= '0;
      end else if (cmd) begin
         case (evt.cs)
            CS_LOAD_LO:  lo_half       <= evt.arg[15:0];
            CS_READ_REG: peek.reg_idx  <= evt.arg[4:0];
            CS_READ_MEM: peek.mem_addr <= evt.arg[7:0];
            default: ;
         endcase
      end
   end

   // Write lands one cycle after the event
   always_comb begin
      imem_wr                    = '0;
      imem_wr.en                 = cmd && (evt.cs == CS_LOAD_HI) && halted;
      imem_wr.addr[IMEM_AW-1:0]  = evt.arg[16 +: IMEM_AW];
      // High half first
      imem_wr.data               = {evt.arg[15:0], lo_half};
   end

   //////////////////////////////////////////////////
   // Readback
   //////////////////////////////////////////////////

   always_ff @(posedge clk50) begin
      if (!rst_n) begin
         // Halted out of reset
         miso <= 32'd1;
      end else begin
         case (evt.cs)
            CS_READ_REG: miso <= view.reg_val;
            CS_READ_PC:  miso <= view.pc;
            CS_READ_MEM: miso <= view.mem_val;
            // Idle and load codes show the halt flag
            default:     miso <= {31'd0, halted};
         endcase
      end
   end

endmodule

//--- source/mips_mem.sv
`timescale 1ns/1ps

module mips_mem import mips_dbg_pkg::*; #(
   parameter int  AW        = 8,
   parameter type word_type = word_t
) (
   input  logic          clk50,
   input  mem_wr_t       wr,
   input  logic [AW-1:0] raddr_a,
   input  logic [AW-1:0] raddr_b,
   output word_type      rdata_a,
   output word_type      rdata_b
);

   localparam int DEPTH = 2 ** AW;

   // Storage, contents undefined until loaded
   word_type mem [DEPTH];

   //////////////////////////////////////////////////
   // Write port
   //////////////////////////////////////////////////

   always_ff @(posedge clk50) begin
      if (wr.en) begin
         // Upper address bits beyond AW are dropped
         mem[wr.addr[AW-1:0]] <= wr.data;
      end
   end

   //////////////////////////////////////////////////
   // Read ports, combinational
   //////////////////////////////////////////////////

   assign rdata_a = mem[raddr_a];
   assign rdata_b = mem[raddr_b];

endmodule

//--- source/mips_core.sv
`timescale 1ns/1ps

module mips_core import mips_dbg_pkg::*; #(
   parameter int IMEM_AW = 8,
   parameter int DMEM_AW = 8
) (
   input  logic               clk50,
   input  logic               rst_n,
   input  logic               run_en,
   input  word_t              instr,
   output logic [IMEM_AW-1:0] imem_addr,
   output logic [DMEM_AW-1:0] dmem_addr,
   input  word_t              dmem_rdata,
   output dmem_wr_t           dmem_wr,
   input  peek_t              peek,
   output logic [DMEM_AW-1:0] peek_mem_addr,
   input  word_t              peek_mem_data,
   output logic               is_halt,
   output core_view_t         view
);

   word_t       pc;
   word_t       regs [32];

   // Instruction fields
   logic [5:0]  op;
   logic [4:0]  rs;
   logic [4:0]  rt;
   logic [4:0]  rd;
   logic [5:0]  funct;
   word_t       imm_sx;

   logic        is_rtype;
   logic        is_addi;
   logic        is_lw;
   logic        is_sw;
   logic        is_beq;

   word_t       rs_val;
   word_t       rt_val;
   word_t       alu_res;

   logic        wr_reg;
   logic [4:0]  wr_idx;
   word_t       wr_val;

   word_t       pc_plus4;
   word_t       pc_next;

   //////////////////////////////////////////////////
   // Decode
   //////////////////////////////////////////////////

   assign op     = instr[31:26];
   assign rs     = instr[25:21];
   assign rt     = instr[20:16];
   assign rd     = instr[15:11];
   assign funct  = instr[5:0];
   assign imm_sx = {{16{instr[15]}}, instr[15:0]};

   assign is_rtype = (op == OP_RTYPE);
   assign is_addi  = (op == OP_ADDI);
   assign is_lw    = (op == OP_LW);
   assign is_sw    = (op == OP_SW);
   assign is_beq   = (op == OP_BEQ);
   assign is_halt  = (op == OP_HALT);

   // Fetch by word address
   assign imem_addr = pc[IMEM_AW+1:2];

   //////////////////////////////////////////////////
   // Register file reads and ALU
   //////////////////////////////////////////////////

   // r0 always reads zero
   assign rs_val = (rs == 5'd0) ? '0 : regs[rs];
   assign rt_val = (rt == 5'd0) ? '0 : regs[rt];

   always_comb begin
      // Immediate sum for addi, lw and sw
      alu_res = rs_val + imm_sx;
      if (is_rtype) begin
         case (funct)
            FN_ADD:  alu_res = rs_val + rt_val;
            FN_SUB:  alu_res = rs_val - rt_val;
            FN_AND:  alu_res = rs_val & rt_val;
            FN_OR:   alu_res = rs_val | rt_val;
            FN_SLT:  alu_res = {31'd0, $signed(rs_val) < $signed(rt_val)};
            default: alu_res = '0;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Data memory
   //////////////////////////////////////////////////

   assign dmem_addr = alu_res[DMEM_AW+1:2];

   always_comb begin
      dmem_wr                   = '0;
      dmem_wr.en                = run_en & is_sw;
      dmem_wr.addr[DMEM_AW-1:0] = dmem_addr;
      dmem_wr.data              = rt_val;
   end

   //////////////////////////////////////////////////
   // Write back
   //////////////////////////////////////////////////

   // rd for R-type, rt for addi and lw
   assign wr_idx = is_rtype ? rd : rt;
   assign wr_reg = run_en && (is_rtype || is_addi || is_lw) && (wr_idx != 5'd0);
   assign wr_val = is_lw ? dmem_rdata : alu_res;

   always_ff @(posedge clk50) begin
      if (!rst_n) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_reg) begin
         regs[wr_idx] <= wr_val;
      end
   end

   //////////////////////////////////////////////////
   // Program counter
   //////////////////////////////////////////////////

   assign pc_plus4 = pc + 32'd4;

   always_comb begin
      pc_next = pc_plus4;
      if (is_halt) begin
         // Halt parks on itself
         pc_next = pc;
      end else if (is_beq && (rs_val == rt_val)) begin
         pc_next = pc_plus4 + {imm_sx[29:0], 2'b00};
      end
   end

   always_ff @(posedge clk50) begin
      if (!rst_n) begin
         pc <= '0;
      end else if (run_en) begin
         pc <= pc_next;
      end
   end

   //////////////////////////////////////////////////
   // Debug view
   //////////////////////////////////////////////////

   assign peek_mem_addr = DMEM_AW'(peek.mem_addr);

   assign view.pc      = pc;
   assign view.reg_val = (peek.reg_idx == 5'd0) ? '0 : regs[peek.reg_idx];
   assign view.mem_val = peek_mem_data;

endmodule

//--- source/top_rtl.sv
`timescale 1ns/1ps

module top_rtl import mips_dbg_pkg::*; #(
   parameter int IMEM_AW     = 8,
   parameter int DMEM_AW     = 8,
   parameter int SYNC_STAGES = 2
) (
   input  logic                 clk50,
   input  logic                 rst_n,
   input  logic                 sclk,
   input  logic                 step,
   input  logic                 cont,
   input  logic [3:0]           cs,
   input  logic [DBG_ARG_W-1:0] mosi,
   output word_t                miso
);

   dbg_evt_t           evt;
   logic               run_en;
   logic               is_halt;
   imem_wr_t           imem_wr;
   dmem_wr_t           dmem_wr;
   peek_t              peek;
   core_view_t         view;
   word_t              instr;
   word_t              dmem_rdata;
   word_t              peek_mem_data;
   logic [IMEM_AW-1:0] imem_addr;
   logic [DMEM_AW-1:0] dmem_addr;
   logic [DMEM_AW-1:0] peek_mem_addr;

   //////////////////////////////////////////////////
   // Host debug side
   //////////////////////////////////////////////////

   dbg_host_sync #(
      .SYNC_STAGES (SYNC_STAGES)
   ) u_sync (
      .clk50 (clk50),
      .rst_n (rst_n),
      .sclk  (sclk),
      .step  (step),
      .cont  (cont),
      .cs    (cs),
      .mosi  (mosi),
      .evt   (evt)
   );

   dbg_ctrl #(
      .IMEM_AW (IMEM_AW)
   ) u_ctrl (
      .clk50   (clk50),
      .rst_n   (rst_n),
      .evt     (evt),
      .is_halt (is_halt),
      .view    (view),
      .run_en  (run_en),
      .imem_wr (imem_wr),
      .peek    (peek),
      .miso    (miso)
   );

   //////////////////////////////////////////////////
   // Core and memories
   //////////////////////////////////////////////////

   mips_core #(
      .IMEM_AW (IMEM_AW),
      .DMEM_AW (DMEM_AW)
   ) u_core (
      .clk50         (clk50),
      .rst_n         (rst_n),
      .run_en        (run_en),
      .instr         (instr),
      .imem_addr     (imem_addr),
      .dmem_addr     (dmem_addr),
      .dmem_rdata    (dmem_rdata),
      .dmem_wr       (dmem_wr),
      .peek          (peek),
      .peek_mem_addr (peek_mem_addr),
      .peek_mem_data (peek_mem_data),
      .is_halt       (is_halt),
      .view          (view)
   );

   // Port b is not needed on the instruction side
   mips_mem #(
      .AW        (IMEM_AW),
      .word_type (word_t)
   ) u_imem (
      .clk50   (clk50),
      .wr      (imem_wr),
      .raddr_a (imem_addr),
      .raddr_b ('0),
      .rdata_a (instr),
      .rdata_b ()
   );

   mips_mem #(
      .AW        (DMEM_AW),
      .word_type (word_t)
   ) u_dmem (
      .clk50   (clk50),
      .wr      (dmem_wr),
      .raddr_a (dmem_addr),
      .raddr_b (peek_mem_addr),
      .rdata_a (dmem_rdata),
      .rdata_b (peek_mem_data)
   );

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int PERIOD_NS  = 100,
   parameter int RST_CYCLES = 4
) (
   output logic clk,
   output logic rst_n
);

   // Free running clock
   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Reset held low for the first few rising edges
   initial begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

//--- dv/tb_top.sv
`timescale 1ns/1ps

module tb_top import mips_dbg_pkg::*; ();

   localparam int CLK_PERIOD  = 100;
   localparam int SYNC_STAGES = 2;
   localparam int IMEM_AW     = 8;
   localparam int DMEM_AW     = 8;
   // Pin hold time around each host edge
   localparam int HOLD        = SYNC_STAGES + 2;
   localparam int POLL_MAX    = 1500;
   localparam int MODEL_MAX   = 10000;
   // Tests need about 2000 cycles and 5000 leaves margin
   localparam int WATCHDOG_CYCLES = 5000;

   logic                 clk;
   logic                 gen_rst_n;
   logic                 ext_rst_n;
   logic                 rst_n;
   logic                 sclk;
   logic                 step;
   logic                 cont;
   logic [3:0]           cs;
   logic [DBG_ARG_W-1:0] mosi;
   word_t                miso;

   // Reference model state
   word_t prog_m [1 << IMEM_AW];
   word_t dmem_m [1 << DMEM_AW];
   word_t regs_m [32];
   word_t pc_m;
   word_t prog_q [$];

   int    seed = 77686;
   int    n_checks;
   int    n_errors;
   int    err_at_start;

   assign rst_n = gen_rst_n & ext_rst_n;

   tb_clk_gen #(
      .PERIOD_NS  (CLK_PERIOD),
      .RST_CYCLES (4)
   ) u_clk_gen (
      .clk   (clk),
      .rst_n (gen_rst_n)
   );

   top_rtl #(
      .IMEM_AW     (IMEM_AW),
      .DMEM_AW     (DMEM_AW),
      .SYNC_STAGES (SYNC_STAGES)
   ) u_dut (
      .clk50 (clk),
      .rst_n (rst_n),
      .sclk  (sclk),
      .step  (step),
      .cont  (cont),
      .cs    (cs),
      .mosi  (mosi),
      .miso  (miso)
   );

   //////////////////////////////////////////////////
   // Encoders and checks
   //////////////////////////////////////////////////

   function automatic word_t next_rand();
      next_rand = $random(seed);
   endfunction

   function automatic word_t r_instr(logic [5:0] fn, logic [4:0] rd, logic [4:0] rs,
                                     logic [4:0] rt);
      r_instr = {OP_RTYPE, rs, rt, rd, 5'd0, fn};
   endfunction

   function automatic word_t i_instr(logic [5:0] op, logic [4:0] rt, logic [4:0] rs,
                                     logic [15:0] imm);
      i_instr = {op, rs, rt, imm};
   endfunction

   // beq offset counts words from the slot after the branch
   function automatic word_t beq_to(logic [4:0] rs, logic [4:0] rt, int from, int to);
      beq_to = i_instr(OP_BEQ, rt, rs, 16'(to - from - 1));
   endfunction

   task automatic check_eq(input string what, input word_t exp, input word_t act);
      n_checks++;
      assert (act === exp) else begin
         $display("ERR %0t ns: %s expected %08h got %08h", $time, what, exp, act);
         n_errors++;
      end
   endtask

   task automatic end_test(input string name);
      $display("Test %s: %s", name, (n_errors == err_at_start) ? "ok" : "FAILED");
      err_at_start = n_errors;
   endtask

   //////////////////////////////////////////////////
   // Host port driver
   //////////////////////////////////////////////////

   // One sclk pulse with cs and mosi held through it
   task automatic send_cmd(input dbg_cs_e sel, input logic [DBG_ARG_W-1:0] arg);
      @(posedge clk);
      cs   <= sel;
      mosi <= arg;
      sclk <= 1'b1;
      repeat (HOLD) @(posedge clk);
      sclk <= 1'b0;
      repeat (HOLD) @(posedge clk);
   endtask

   task automatic load_word(input logic [8:0] addr, input word_t w);
      send_cmd(CS_LOAD_LO, {9'd0, w[15:0]});
      send_cmd(CS_LOAD_HI, {addr, w[31:16]});
      @(posedge clk);
      cs   <= CS_IDLE;
      mosi <= '0;
   endtask

   task automatic read_back(input dbg_cs_e sel, input logic [DBG_ARG_W-1:0] arg,
                            output word_t val);
      @(posedge clk);
      cs   <= sel;
      mosi <= arg;
      sclk <= 1'b1;
      repeat (SYNC_STAGES + 4) @(posedge clk);
      @(negedge clk);
      val = miso;
      @(posedge clk);
      sclk <= 1'b0;
      cs   <= CS_IDLE;
      mosi <= '0;
      repeat (HOLD) @(posedge clk);
   endtask

   task automatic idle_miso(output word_t val);
      @(posedge clk);
      cs <= CS_IDLE;
      repeat (SYNC_STAGES + 3) @(posedge clk);
      @(negedge clk);
      val = miso;
   endtask

   task automatic step_once();
      @(posedge clk);
      step <= 1'b1;
      repeat (HOLD) @(posedge clk);
      step <= 1'b0;
      repeat (HOLD) @(posedge clk);
   endtask

   task automatic kick_run();
      @(posedge clk);
      cont <= 1'b1;
      repeat (HOLD) @(posedge clk);
      cont <= 1'b0;
      repeat (HOLD) @(posedge clk);
   endtask

   // Poll the halt flag on idle MISO
   task automatic wait_halted();
      logic done;
      int   n;
      done = 1'b0;
      repeat (SYNC_STAGES + 4) @(posedge clk);
      for (n = 0; n < POLL_MAX && !done; n++) begin
         @(negedge clk);
         done = miso[0];
      end
      if (!done) begin
         $display("The core never halted within %0d polled cycles", POLL_MAX);
         n_errors++;
      end
   endtask

   task automatic run_to_halt();
      kick_run();
      wait_halted();
   endtask

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////

   task automatic clear_model();
      pc_m = '0;
      foreach (regs_m[i]) begin
         regs_m[i] = '0;
      end
   endtask

   // Writes prog_q at the current pc into both the DUT and the model
   task automatic load_program();
      logic [IMEM_AW-1:0] wa;
      for (int i = 0; i < prog_q.size(); i++) begin
         wa = pc_m[IMEM_AW+1:2] + IMEM_AW'(i);
         load_word({1'b0, wa}, prog_q[i]);
         prog_m[wa] = prog_q[i];
      end
   endtask

   task automatic exec_one(output logic halted);
      word_t      ins;
      word_t      a;
      word_t      b;
      word_t      imm;
      word_t      res;
      logic [4:0] rt;
      logic [4:0] rd;
      ins    = prog_m[pc_m[IMEM_AW+1:2]];
      a      = regs_m[ins[25:21]];
      b      = regs_m[ins[20:16]];
      rt     = ins[20:16];
      rd     = ins[15:11];
      imm    = {{16{ins[15]}}, ins[15:0]};
      res    = a + imm;
      halted = 1'b0;
      case (ins[31:26])
         OP_RTYPE: begin
            case (ins[5:0])
               FN_ADD:  res = a + b;
               FN_SUB:  res = a - b;
               FN_AND:  res = a & b;
               FN_OR:   res = a | b;
               FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
               default: res = '0;
            endcase
            if (rd != 5'd0) begin
               regs_m[rd] = res;
            end
         end
         OP_ADDI: begin
            if (rt != 5'd0) begin
               regs_m[rt] = res;
            end
         end
         OP_LW: begin
            if (rt != 5'd0) begin
               regs_m[rt] = dmem_m[res[DMEM_AW+1:2]];
            end
         end
         OP_SW: dmem_m[res[DMEM_AW+1:2]] = b;
         OP_HALT: halted = 1'b1;
         default: ;
      endcase
      // Halt parks and beq jumps relative to pc+4
      if (!halted) begin
         if (ins[31:26] == OP_BEQ && a == b) begin
            pc_m = pc_m + 32'd4 + {imm[29:0], 2'b00};
         end else begin
            pc_m = pc_m + 32'd4;
         end
      end
   endtask

   task automatic exec_to_halt();
      logic done;
      int   n;
      done = 1'b0;
      for (n = 0; n < MODEL_MAX && !done; n++) begin
         exec_one(done);
      end
      if (!done) begin
         $display("The reference model did not reach a halt");
         n_errors++;
      end
   endtask

   //////////////////////////////////////////////////
   // Readback helpers
   //////////////////////////////////////////////////

   task automatic check_reg(input logic [4:0] r);
      word_t v;
      read_back(CS_READ_REG, {20'd0, r}, v);
      check_eq($sformatf("r%0d", r), regs_m[r], v);
   endtask

   task automatic check_pc();
      word_t v;
      read_back(CS_READ_PC, '0, v);
      check_eq("pc", pc_m, v);
   endtask

   task automatic check_mem(input logic [7:0] wa);
      word_t v;
      read_back(CS_READ_MEM, {17'd0, wa}, v);
      check_eq($sformatf("mem[%0d]", wa), dmem_m[wa], v);
   endtask

   task automatic check_halted(input word_t exp);
      word_t v;
      idle_miso(v);
      check_eq("idle miso", exp, v);
   endtask

   // Countdown loop with four instructions per pass
   task automatic build_countdown(input int count);
      prog_q.delete();
      prog_q.push_back(i_instr(OP_ADDI, 5'd20, 5'd0, 16'(count)));
      prog_q.push_back(i_instr(OP_ADDI, 5'd21, 5'd0, 16'd1));
      prog_q.push_back(i_instr(OP_ADDI, 5'd22, 5'd0, 16'd0));
      prog_q.push_back(r_instr(FN_ADD, 5'd22, 5'd22, 5'd20));
      prog_q.push_back(r_instr(FN_SUB, 5'd20, 5'd20, 5'd21));
      prog_q.push_back(beq_to(5'd20, 5'd0, 5, 7));
      prog_q.push_back(beq_to(5'd0, 5'd0, 6, 3));
      prog_q.push_back({OP_HALT, 26'd0});
   endtask

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////

   initial begin
      word_t              rnd;
      word_t              rnd2;
      logic               halted;
      logic [IMEM_AW-1:0] live;
      logic [7:0]         wa;
      sclk      = 1'b0;
      step      = 1'b0;
      cont      = 1'b0;
      cs        = '0;
      mosi      = '0;
      ext_rst_n = 1'b1;
      n_checks  = 0;
      n_errors  = 0;
      err_at_start = 0;
      clear_model();
      wait (gen_rst_n === 1'b1);
      repeat (2) @(posedge clk);

      // Test 1 reads the state out of reset
      rnd = next_rand();
      check_halted(32'd1);
      check_pc();
      check_reg(rnd[4:0]);
      end_test("reset state");

      // Test 2 loads addi into r1..r8 and one into r0, then single steps
      prog_q.delete();
      for (int i = 1; i <= 8; i++) begin
         rnd = next_rand();
         prog_q.push_back(i_instr(OP_ADDI, 5'(i), 5'd0, rnd[15:0]));
         if (i == 4) begin
            rnd = next_rand();
            prog_q.push_back(i_instr(OP_ADDI, 5'd0, 5'd1, rnd[15:0]));
         end
      end
      prog_q.push_back({OP_HALT, 26'd0});
      load_program();
      for (int k = 0; k < 9; k++) begin
         step_once();
         exec_one(halted);
         check_pc();
         check_reg(prog_q[k][20:16]);
      end
      end_test("load and step");

      // Test 3 runs a summing loop whose exit depends on slt
      rnd = next_rand();
      prog_q.delete();
      prog_q.push_back(i_instr(OP_ADDI, 5'd9, 5'd0, {13'd0, rnd[2:0]} + 16'd4));
      prog_q.push_back(i_instr(OP_ADDI, 5'd10, 5'd0, 16'd0));
      prog_q.push_back(i_instr(OP_ADDI, 5'd11, 5'd0, 16'd1));
      prog_q.push_back(r_instr(FN_ADD, 5'd10, 5'd10, 5'd9));
      prog_q.push_back(r_instr(FN_SUB, 5'd9, 5'd9, 5'd11));
      prog_q.push_back(r_instr(FN_SLT, 5'd12, 5'd0, 5'd9));
      prog_q.push_back(beq_to(5'd12, 5'd0, 6, 8));
      prog_q.push_back(beq_to(5'd0, 5'd0, 7, 3));
      prog_q.push_back(r_instr(FN_AND, 5'd13, 5'd10, 5'd1));
      prog_q.push_back(r_instr(FN_OR, 5'd14, 5'd10, 5'd2));
      prog_q.push_back({OP_HALT, 26'd0});
      load_program();
      run_to_halt();
      exec_to_halt();
      check_halted(32'd1);
      check_pc();
      for (int r = 9; r <= 14; r++) begin
         check_reg(5'(r));
      end
      end_test("continue to halt");

      // Test 4 stores two random words and loads them back
      rnd  = next_rand();
      rnd2 = next_rand();
      wa   = {rnd2[22:16], 1'b0};
      prog_q.delete();
      prog_q.push_back(i_instr(OP_ADDI, 5'd15, 5'd0, rnd[15:0]));
      prog_q.push_back(i_instr(OP_ADDI, 5'd16, 5'd0, rnd2[15:0]));
      prog_q.push_back(i_instr(OP_SW, 5'd15, 5'd0, {6'd0, wa, 2'b00}));
      prog_q.push_back(i_instr(OP_SW, 5'd16, 5'd0, {6'd0, wa + 8'd1, 2'b00}));
      prog_q.push_back(i_instr(OP_LW, 5'd17, 5'd0, {6'd0, wa, 2'b00}));
      prog_q.push_back(i_instr(OP_LW, 5'd18, 5'd0, {6'd0, wa + 8'd1, 2'b00}));
      prog_q.push_back({OP_HALT, 26'd0});
      load_program();
      run_to_halt();
      exec_to_halt();
      check_mem(wa);
      check_mem(wa + 8'd1);
      check_reg(5'd17);
      check_reg(5'd18);
      check_pc();
      end_test("data memory");

      // Test 5 writes the loop body while running and expects no change
      build_countdown(150);
      live = pc_m[IMEM_AW+1:2] + IMEM_AW'(3);
      load_program();
      kick_run();
      load_word({1'b0, live}, r_instr(FN_SUB, 5'd22, 5'd22, 5'd20));
      wait_halted();
      exec_to_halt();
      check_pc();
      check_reg(5'd20);
      check_reg(5'd22);
      end_test("load while running");

      // Test 6 resets in the middle of a long run
      build_countdown(200);
      load_program();
      kick_run();
      check_halted(32'd0);
      @(posedge clk);
      ext_rst_n <= 1'b0;
      repeat (2) @(posedge clk);
      ext_rst_n <= 1'b1;
      clear_model();
      repeat (2) @(posedge clk);
      rnd = next_rand();
      check_halted(32'd1);
      check_pc();
      check_reg(rnd[4:0]);
      check_reg(5'd22);
      end_test("reset mid-run");

      $display("Checks run: %0d, failures: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   //////////////////////////////////////////////////
   // Watchdog
   //////////////////////////////////////////////////

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
      $display("Test failures found");
      $finish;
   end

endmodule

//--- all.f
source/mips_dbg_pkg.sv
source/dbg_host_sync.sv
source/dbg_ctrl.sv
source/mips_mem.sv
source/mips_core.sv
source/top_rtl.sv
dv/tb_clk_gen.sv
dv/tb_top.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_top
FILELIST  = all.f

SIM = obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Output goes to the console, pass is decided by a search for the pass line
run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
